/* files.f */
hw/rf_pkg.sv
hw/rf_array_4x26.sv
hw/rf_mem_pg_4x26.sv
hw/rf_pg_ctrl.sv
hw/rf_subsys_top.sv
tests/rf_subsys_sva.sv
tests/tb_rf_subsys.sv

/* hw/rf_array_4x26.sv */
//----------------------------------------
// Storage array for the 4x26 register file
// Registered read port, contents are lost
// while the array power is off
//----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rf_array_4x26 (
     input  logic               clk
    ,input  logic               rst_n

    // Power state seen at the far end of the power chain
    ,input  logic               array_pwr_off

    ,input  logic               wr_en
    ,input  rf_pkg::rf_wr_req_t wr_req

    ,input  logic               rd_en
    ,input  rf_pkg::rf_rd_req_t rd_req

    ,output rf_pkg::rf_data_t   rd_data
    ,output logic               rd_data_valid
);

    //----------------------------------------
    // Storage
    //----------------------------------------

    // Data words carry no reset, the written flags say what is valid
    rf_pkg::rf_data_t                mem [rf_pkg::RF_DEPTH];
    logic [rf_pkg::RF_DEPTH-1:0]     written;

    // Word as seen by the read port, zero if never written
    rf_pkg::rf_data_t                rd_word;

    always_comb begin
        if (written[rd_req.addr] && !array_pwr_off) begin
            rd_word = mem[rd_req.addr];
        end else begin
            rd_word = '0;
        end
    end

    // Write side, writes while unpowered go nowhere
    always_ff @(posedge clk) begin
        if (wr_en && !array_pwr_off) begin
            mem[wr_req.addr] <= wr_req.data;
        end
    end

    // Written flags drop together as soon as the array loses power
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            written <= '0;
        end else if (array_pwr_off) begin
            written <= '0;
        end else if (wr_en) begin
            written[wr_req.addr] <= 1'b1;
        end
    end

    //----------------------------------------
    // Read port
    //----------------------------------------

    // Data is sampled before this edge's write lands, so a same-edge
    // write and read to one entry returns the old word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= rd_word;
        end
    end

    // One-cycle valid pulse per accepted read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= rd_en;
        end
    end

endmodule

`default_nettype wire

/* hw/rf_mem_pg_4x26.sv */
//----------------------------------------
// Power-gated 4x26 memory wrapper
// Power chain delay, output isolation clamp
// and the storage array
//----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rf_mem_pg_4x26 (
     input  logic               clk
    ,input  logic               rst_n

    ,input  logic               wr_en
    ,input  rf_pkg::rf_wr_req_t wr_req

    ,input  logic               rd_en
    ,input  rf_pkg::rf_rd_req_t rd_req

    ,output rf_pkg::rf_data_t   rdata
    ,output logic               rdata_valid

    // Power interface, pwr_enable_b high means off
    ,input  logic               isol_en
    ,input  logic               pwr_enable_b_in
    ,output logic               pwr_enable_b_out
);

    //----------------------------------------
    // Power chain
    //----------------------------------------

    // The macro's power switches are daisy chained, the enable walks
    // through them one stage per cycle before the echo comes back
    logic [rf_pkg::PG_CHAIN_DELAY-1:0] pwr_chain;
    logic                              array_pwr_off;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pwr_chain <= '0;
        end else begin
            pwr_chain <= {pwr_chain[rf_pkg::PG_CHAIN_DELAY-2:0], pwr_enable_b_in};
        end
    end

    // Last stage is both the echo and the array's own view of power
    assign array_pwr_off    = pwr_chain[rf_pkg::PG_CHAIN_DELAY-1];
    assign pwr_enable_b_out = array_pwr_off;

    //----------------------------------------
    // Storage array
    //----------------------------------------

    rf_pkg::rf_data_t arr_rd_data;
    logic             arr_rd_valid;

    rf_array_4x26 u_array (
         .clk           (clk)
        ,.rst_n         (rst_n)
        ,.array_pwr_off (array_pwr_off)
        ,.wr_en         (wr_en)
        ,.wr_req        (wr_req)
        ,.rd_en         (rd_en)
        ,.rd_req        (rd_req)
        ,.rd_data       (arr_rd_data)
        ,.rd_data_valid (arr_rd_valid)
    );

    //----------------------------------------
    // Output hold and isolation
    //----------------------------------------

    // Isolation is taken through a flop at the macro boundary
    logic             isol_q;
    // Last delivered read word, kept between reads
    rf_pkg::rf_data_t rdata_hold;
    rf_pkg::rf_data_t rdata_raw;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            isol_q     <= 1'b0;
            rdata_hold <= '0;
        end else begin
            isol_q <= isol_en;
            if (arr_rd_valid) begin
                rdata_hold <= arr_rd_data;
            end
        end
    end

    // Fresh data passes straight through in its valid cycle
    assign rdata_raw   = arr_rd_valid ? arr_rd_data : rdata_hold;

    // Clamp to zero so nothing floats out of an unpowered macro
    assign rdata       = isol_q ? '0 : rdata_raw;
    assign rdata_valid = arr_rd_valid;

endmodule

`default_nettype wire

/* hw/rf_pg_ctrl.sv */
//----------------------------------------
// Power-gate sequencer
// Drains, isolates and powers the memory
// down on sleep, and reverses it on wake
//----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rf_pg_ctrl (
     input  logic clk
    ,input  logic rst_n

    // Sleep request is a level, held for as long as sleep is wanted
    ,input  logic sleep_req

    // Raw access strobes from the requester
    ,input  logic we
    ,input  logic re

    // Power chain echo from the wrapper, high once fully off
    ,input  logic pwr_ack_b

    ,output logic busy
    ,output logic wr_en
    ,output logic rd_en
    ,output logic isol_en
    ,output logic pwr_enable_b
);

    //----------------------------------------
    // State register
    //----------------------------------------

    rf_pkg::pg_state_e state_q;
    rf_pkg::pg_state_e state_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= rf_pkg::PG_ON;
        end else begin
            state_q <= state_d;
        end
    end

    //----------------------------------------
    // Next state
    //----------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            rf_pkg::PG_ON: begin
                if (sleep_req) begin
                    state_d = rf_pkg::PG_DRAIN;
                end
            end
            // Single cycle, lets the last accepted read come out unclamped
            rf_pkg::PG_DRAIN: begin
                state_d = rf_pkg::PG_ISOLATE;
            end
            rf_pkg::PG_ISOLATE: begin
                state_d = rf_pkg::PG_POWER_DOWN;
            end
            // Echo high means every switch in the chain is open
            rf_pkg::PG_POWER_DOWN: begin
                if (pwr_ack_b) begin
                    state_d = rf_pkg::PG_OFF;
                end
            end
            rf_pkg::PG_OFF: begin
                if (!sleep_req) begin
                    state_d = rf_pkg::PG_POWER_UP;
                end
            end
            // Wait for the whole chain to report power restored
            rf_pkg::PG_POWER_UP: begin
                if (!pwr_ack_b) begin
                    state_d = rf_pkg::PG_RELEASE;
                end
            end
            rf_pkg::PG_RELEASE: begin
                state_d = rf_pkg::PG_ON;
            end
            // Unused encoding, recover to the operating state
            default: begin
                state_d = rf_pkg::PG_ON;
            end
        endcase
    end

    //----------------------------------------
    // Power and isolation controls
    //----------------------------------------

    // Both outputs are decoded from the next state and registered,
    // so they change on the edge that enters the state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            isol_en      <= 1'b0;
            pwr_enable_b <= 1'b0;
        end else begin
            // Clamp on from ISOLATE through POWER_UP, off again in RELEASE
            isol_en      <= state_d inside {rf_pkg::PG_ISOLATE,
                                            rf_pkg::PG_POWER_DOWN,
                                            rf_pkg::PG_OFF,
                                            rf_pkg::PG_POWER_UP};
            // Power is removed only across POWER_DOWN and OFF
            pwr_enable_b <= state_d inside {rf_pkg::PG_POWER_DOWN,
                                            rf_pkg::PG_OFF};
        end
    end

    //----------------------------------------
    // Access gating
    //----------------------------------------

    // Accesses are only taken while fully on, anything else is dropped
    assign busy  = (state_q != rf_pkg::PG_ON);
    assign wr_en = we && !busy;
    assign rd_en = re && !busy;

endmodule

`default_nettype wire

/* hw/rf_pkg.sv */
//----------------------------------------
// Register file subsystem package
// Sizes, request structs, the power-gate
// sequencer states and timing constants
//----------------------------------------

`default_nettype none

package rf_pkg;

    //----------------------------------------
    // Array geometry
    //----------------------------------------

    // Four entries of 26 bits, matching the 4x26 macro
    localparam int RF_DEPTH  = 4;
    localparam int RF_ADDR_W = 2;
    localparam int RF_DATA_W = 26;

    //----------------------------------------
    // Power chain timing
    //----------------------------------------

    // Cycles the power enable takes to ripple through the macro's
    // power switches and come back out as the echo
    localparam int PG_CHAIN_DELAY = 3;

    //----------------------------------------
    // Request types
    //----------------------------------------

    typedef logic [RF_ADDR_W-1:0] rf_addr_t;
    typedef logic [RF_DATA_W-1:0] rf_data_t;

    // Write port payload, qualified by a separate strobe
    typedef struct packed {
        rf_addr_t addr;
        rf_data_t data;
    } rf_wr_req_t;

    // Read port payload, data comes back one cycle later
    typedef struct packed {
        rf_addr_t addr;
    } rf_rd_req_t;

    //----------------------------------------
    // Power-gate sequencer states
    //----------------------------------------

    // Sleep walks down the list and wake walks back up through
    // POWER_UP and RELEASE, PG_ON is the only state that takes accesses
    typedef enum logic [2:0] {
        PG_ON         = 3'd0,
        // One idle cycle so a read in flight lands before the clamp
        PG_DRAIN      = 3'd1,
        // Output clamp goes on, memory still powered
        PG_ISOLATE    = 3'd2,
        // Power enable dropped, waiting for the chain echo
        PG_POWER_DOWN = 3'd3,
        // Fully off, held here while sleep is requested
        PG_OFF        = 3'd4,
        // Power enable restored, waiting for the echo to clear
        PG_POWER_UP   = 3'd5,
        // Clamp released on the way back to PG_ON
        PG_RELEASE    = 3'd6
    } pg_state_e;

endpackage

`default_nettype wire

/* hw/rf_subsys_top.sv */
//----------------------------------------
// Power-gated register file subsystem
// Sequencer plus the 4x26 memory wrapper
//----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rf_subsys_top (
     input  logic               clk
    ,input  logic               rst_n

    // Sleep control
    ,input  logic               sleep_req

    // Write port
    ,input  logic               we
    ,input  rf_pkg::rf_wr_req_t wr_req

    // Read port
    ,input  logic               re
    ,input  rf_pkg::rf_rd_req_t rd_req

    ,output rf_pkg::rf_data_t   rdata
    ,output logic               rdata_valid

    // Status
    ,output logic               busy
    ,output logic               pwr_off
);

    //----------------------------------------
    // Internal connections
    //----------------------------------------

    // Strobes after qualification by the sequencer
    logic wr_en;
    logic rd_en;

    // Power controls toward the wrapper and the echo coming back
    logic isol_en;
    logic pwr_enable_b;
    logic pwr_enable_b_out;

    rf_pg_ctrl u_pg_ctrl (
         .clk          (clk)
        ,.rst_n        (rst_n)
        ,.sleep_req    (sleep_req)
        ,.we           (we)
        ,.re           (re)
        ,.pwr_ack_b    (pwr_enable_b_out)
        ,.busy         (busy)
        ,.wr_en        (wr_en)
        ,.rd_en        (rd_en)
        ,.isol_en      (isol_en)
        ,.pwr_enable_b (pwr_enable_b)
    );

    rf_mem_pg_4x26 u_mem (
         .clk              (clk)
        ,.rst_n            (rst_n)
        ,.wr_en            (wr_en)
        ,.wr_req           (wr_req)
        ,.rd_en            (rd_en)
        ,.rd_req           (rd_req)
        ,.rdata            (rdata)
        ,.rdata_valid      (rdata_valid)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // The echo doubles as the externally visible power-off status
    assign pwr_off = pwr_enable_b_out;

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the register file subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_rf_subsys \
    -f files.f \
    -o sim_rf_subsys

# Keep going on a nonzero exit so the output can still be searched
status=0
sim_out=$(./obj_dir/sim_rf_subsys 2>&1) || status=$?
echo "$sim_out"
echo "simulator exit status: $status"

if grep -q "SIMULATION PASSED" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

/* tests/rf_subsys_sva.sv */
//----------------------------------------
// Concurrent checks for the register file
// subsystem, bound into the top level
//----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rf_subsys_sva (
     input  logic             clk
    ,input  logic             rst_n
    ,input  logic             rd_en
    ,input  logic             rdata_valid
    ,input  logic             busy
    ,input  logic             pwr_off
    ,input  rf_pkg::rf_data_t rdata
    // Registered isolation inside the memory wrapper
    ,input  logic             isol_q
);

    // Valid only ever follows an accepted read, and always does
    a_valid_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |-> $past(rd_en)) else $error("rdata_valid without a read");
    a_read_gives_valid: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |=> rdata_valid) else $error("accepted read gave no rdata_valid");

    // No access can slip in while the memory is unpowered
    a_busy_when_off: assert property (@(posedge clk) disable iff (!rst_n)
        pwr_off |-> busy) else $error("pwr_off high while not busy");

    a_isol_clamp: assert property (@(posedge clk) disable iff (!rst_n)
        isol_q |-> (rdata == '0)) else $error("rdata not clamped while isolated");

    a_reset_power_on: assert property (@(posedge clk)
        $rose(rst_n) |-> !pwr_off) else $error("pwr_off high after reset");

endmodule

bind rf_subsys_top rf_subsys_sva u_sva (
     .clk         (clk)
    ,.rst_n       (rst_n)
    ,.rd_en       (rd_en)
    ,.rdata_valid (rdata_valid)
    ,.busy        (busy)
    ,.pwr_off     (pwr_off)
    ,.rdata       (rdata)
    ,.isol_q      (u_mem.isol_q)
);

`default_nettype wire

/* tests/tb_rf_subsys.sv */
//----------------------------------------
// Testbench for the power-gated register file
// Seeded random accesses and sleep bursts
// checked against a reference model
//----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_rf_subsys;

    localparam int NUM_CYCLES   = 3000;
    // Cycles allowed from sleep_req falling to busy falling
    localparam int WAKE_TIMEOUT = 20;

    logic               clk;
    logic               rst_n;
    logic               sleep_req;
    logic               we;
    rf_pkg::rf_wr_req_t wr_req;
    logic               re;
    rf_pkg::rf_rd_req_t rd_req;
    rf_pkg::rf_data_t   rdata;
    logic               rdata_valid;
    logic               busy;
    logic               pwr_off;

    rf_subsys_top u_dut (
         .clk         (clk)
        ,.rst_n       (rst_n)
        ,.sleep_req   (sleep_req)
        ,.we          (we)
        ,.wr_req      (wr_req)
        ,.re          (re)
        ,.rd_req      (rd_req)
        ,.rdata       (rdata)
        ,.rdata_valid (rdata_valid)
        ,.busy        (busy)
        ,.pwr_off     (pwr_off)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    //----------------------------------------
    // Reference model
    //----------------------------------------

    // Model words and written flags are cleared whenever power is seen off
    rf_pkg::rf_data_t              words [rf_pkg::RF_DEPTH];
    logic [rf_pkg::RF_DEPTH-1:0]   flags;
    // Expected read words, at most one entry between accept and check
    rf_pkg::rf_data_t              exp_q [$];
    // Marks reads that must come back zero after a lost power cycle
    bit                            lost_q [$];
    bit                            saw_pwr_off;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "check failed");
    endtask

    // Called right after a falling edge, when all outputs are settled
    task automatic check_outputs();
        rf_pkg::rf_data_t exp_word;
        logic             exp_valid;
        bit               exp_lost;
        exp_word  = '0;
        exp_valid = 1'b0;
        exp_lost  = 1'b0;
        if (exp_q.size() > 0) begin
            exp_word  = exp_q.pop_front();
            exp_lost  = lost_q.pop_front();
            exp_valid = 1'b1;
        end
        assert (rdata_valid == exp_valid) else
            report_error($sformatf("Error: rdata_valid = %h, expected %h",
                                   rdata_valid, exp_valid));
        if (exp_valid) begin
            // Contents must not survive a sleep that reached power off
            assert (!exp_lost || rdata == '0) else
                report_error($sformatf("Error: rdata = %h after power loss, expected %h",
                                       rdata, rf_pkg::rf_data_t'(0)));
            assert (rdata == exp_word) else
                report_error($sformatf("Error: rdata = %h, expected %h", rdata, exp_word));
        end
        if (pwr_off) begin
            saw_pwr_off = 1'b1;
            flags       = '0;
            assert (rdata == '0) else
                report_error($sformatf("Error: rdata = %h while powered off, expected %h",
                                       rdata, rf_pkg::rf_data_t'(0)));
        end
    endtask

    task automatic tick();
        @(negedge clk);
        check_outputs();
    endtask

    // Drives one cycle of inputs and updates the model with the busy
    // level that the DUT samples at the coming rising edge
    task automatic apply_inputs(input logic sleep, input logic we_v,
                                input rf_pkg::rf_addr_t waddr, input rf_pkg::rf_data_t wdata,
                                input logic re_v, input rf_pkg::rf_addr_t raddr,
                                input bit lost);
        sleep_req      = sleep;
        we             = we_v;
        wr_req.addr    = waddr;
        wr_req.data    = wdata;
        re             = re_v;
        rd_req.addr    = raddr;
        // Read sees the old word, so it goes before the write
        if (re_v && !busy) begin
            exp_q.push_back(flags[raddr] ? words[raddr] : '0);
            lost_q.push_back(lost);
        end
        if (we_v && !busy) begin
            words[waddr] = wdata;
            flags[waddr] = 1'b1;
        end
    endtask

    task automatic random_cycle(input logic sleep);
        apply_inputs(sleep, ($urandom_range(0, 1) == 1),
                     rf_pkg::rf_addr_t'($urandom_range(0, 3)), rf_pkg::rf_data_t'($urandom),
                     ($urandom_range(0, 1) == 1),
                     rf_pkg::rf_addr_t'($urandom_range(0, 3)), 1'b0);
        tick();
    endtask

    //----------------------------------------
    // Scenarios
    //----------------------------------------

    // Unwritten read, then a same-edge write and read to one entry
    task automatic directed_sequence();
        apply_inputs(1'b0, 1'b0, 2'd0, '0, 1'b1, 2'd2, 1'b0);
        tick();
        apply_inputs(1'b0, 1'b1, 2'd1, 26'h2ABCDEF, 1'b0, 2'd0, 1'b0);
        tick();
        apply_inputs(1'b0, 1'b1, 2'd1, 26'h1234567, 1'b1, 2'd1, 1'b0);
        tick();
        apply_inputs(1'b0, 1'b0, 2'd0, '0, 1'b1, 2'd1, 1'b0);
        tick();
    endtask

    task automatic sleep_burst(input int len);
        saw_pwr_off = 1'b0;
        repeat (len) random_cycle(1'b1);
    endtask

    // Keeps poking random strobes while the sequencer wakes up
    task automatic wait_wake();
        int n;
        for (n = 0; n < WAKE_TIMEOUT && busy; n++) begin
            random_cycle(1'b0);
        end
        assert (!busy) else
            report_error("busy stayed high for 20 cycles after sleep_req fell");
        assert (!pwr_off) else
            report_error($sformatf("Error: pwr_off = %h after wake-up, expected %h",
                                   pwr_off, 1'b0));
    endtask

    // Reads every entry with no writes in between
    task automatic read_sweep();
        int a;
        for (a = 0; a < rf_pkg::RF_DEPTH; a++) begin
            apply_inputs(1'b0, 1'b0, 2'd0, '0, 1'b1, rf_pkg::rf_addr_t'(a), saw_pwr_off);
            tick();
        end
    endtask

    //----------------------------------------
    // Main sequence
    //----------------------------------------

    initial begin
        int unsigned seed_val;
        int          cyc;
        seed_val    = $urandom(7085);
        rst_n       = 1'b0;
        sleep_req   = 1'b0;
        we          = 1'b0;
        re          = 1'b0;
        wr_req      = '0;
        rd_req      = '0;
        flags       = '0;
        saw_pwr_off = 1'b0;
        for (cyc = 0; cyc < rf_pkg::RF_DEPTH; cyc++) begin
            words[cyc] = '0;
        end

        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        assert (!busy && !pwr_off && !rdata_valid && rdata == '0) else
            report_error($sformatf(
                "Error: after reset busy=%h pwr_off=%h rdata_valid=%h rdata=%h",
                busy, pwr_off, rdata_valid, rdata));

        directed_sequence();

        for (cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            if ($urandom_range(0, 29) == 0) begin
                sleep_burst(int'($urandom_range(1, 12)));
                wait_wake();
                read_sweep();
            end else begin
                random_cycle(1'b0);
            end
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
